// ==== slot_distrib.f ====
+incdir+testbench
hdl/dispatch_pkg.sv
hdl/lane_if.sv
hdl/class_resolve.sv
hdl/slot_picker.sv
hdl/port_router.sv
hdl/slot_distrib.sv
testbench/slot_distrib_tb.sv

// ==== Bender.yml ====
package:
  name: slot_distrib

sources:
  - files:
      - hdl/dispatch_pkg.sv
      - hdl/lane_if.sv
      - hdl/class_resolve.sv
      - hdl/slot_picker.sv
      - hdl/port_router.sv
      - hdl/slot_distrib.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/slot_distrib_tb.sv

// ==== testbench/distrib_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model of the slot distributor with class priority,
// nth-slot search, port prediction and group pointer state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DISTRIB_MODEL_SVH
`define DISTRIB_MODEL_SVH

// model copies of the memory and shift pointers
int         model_r;
int         model_s;
slot_mask_t model_pos [9];

// mask of one class after all higher classes took their slots
function automatic slot_mask_t exclusive_mask(input int cls, input slot_mask_t sto,
                                              input slot_mask_t ld, input slot_mask_t al,
                                              input slot_mask_t sh);
  slot_mask_t raw [4];
  slot_mask_t claimed;
  raw[0] = sto;
  raw[1] = ld;
  raw[2] = al;
  raw[3] = sh;
  claimed = '0;
  for (int c = 0; c < cls; c++) begin
    claimed = claimed | raw[c];
  end
  return raw[cls] & ~claimed;
endfunction

// one-hot of the n-th set slot (n from 0) counting upward from slot 0
function automatic slot_mask_t nth_slot(input slot_mask_t m, input int n);
  int seen;
  seen = 0;
  for (int k = 0; k < SLOT_CNT; k++) begin
    if (m[k]) begin
      if (seen == n) begin
        return slot_mask_t'(1) << k;
      end
      seen = seen + 1;
    end
  end
  return EMPTY_SEL;
endfunction

// set slots saturated at one group's width
function automatic int class_count(input slot_mask_t m);
  int cnt;
  cnt = 0;
  for (int k = 0; k < SLOT_CNT; k++) begin
    if (m[k]) begin
      cnt = cnt + 1;
    end
  end
  return (cnt > 3) ? 3 : cnt;
endfunction

task automatic reset_model();
  model_r = 0;
  model_s = 0;
endtask

// fills model_pos for the present bundle and pointers
task automatic predict_ports(input slot_mask_t sto, input slot_mask_t ld,
                             input slot_mask_t al, input slot_mask_t sh);
  slot_mask_t st_m;
  slot_mask_t ld_m;
  slot_mask_t al_m;
  slot_mask_t sh_m;
  slot_mask_t entry [3];
  int         n_st;
  st_m = exclusive_mask(CLS_STORE, sto, ld, al, sh);
  ld_m = exclusive_mask(CLS_LOAD, sto, ld, al, sh);
  al_m = exclusive_mask(CLS_ALU, sto, ld, al, sh);
  sh_m = exclusive_mask(CLS_SHIFT, sto, ld, al, sh);
  n_st = class_count(st_m);
  // stores first and loads behind them
  for (int k = 0; k < 3; k++) begin
    if (k < n_st) begin
      entry[k] = nth_slot(st_m, k);
    end else begin
      entry[k] = nth_slot(ld_m, k - n_st);
    end
  end
  for (int k = 0; k < 3; k++) begin
    model_pos[k]     = entry[(k + model_r) % 3];
    model_pos[3 + k] = nth_slot(al_m, k);
    model_pos[6 + k] = nth_slot(sh_m, (k + model_s) % 3);
  end
endtask

// pointer step at a rising edge
task automatic advance_pointers(input logic stall_in, input slot_mask_t sto,
                                input slot_mask_t ld, input slot_mask_t al,
                                input slot_mask_t sh);
  int n_st;
  int n_ld;
  int placed;
  int n_sh;
  n_st = class_count(exclusive_mask(CLS_STORE, sto, ld, al, sh));
  n_ld = class_count(exclusive_mask(CLS_LOAD, sto, ld, al, sh));
  n_sh = class_count(exclusive_mask(CLS_SHIFT, sto, ld, al, sh));
  placed = (n_ld < 3 - n_st) ? n_ld : 3 - n_st;
  if (!stall_in) begin
    model_r = (model_r + 3 - placed) % 3;
    model_s = (model_s + 3 - n_sh) % 3;
  end
endtask

`endif

// ==== testbench/slot_distrib_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot distributor testbench with a table of hand and random
// bundles, model comparison, timeout and summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module slot_distrib_tb;
  import dispatch_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int SEED       = 11143;
  localparam int N_FIXED    = 17;
  localparam int N_RANDOM   = 48;
  localparam int TABLE_LEN  = N_FIXED + N_RANDOM;
  localparam int RST_CYCLES = 4;
  localparam int MAX_CYCLES = TABLE_LEN + RST_CYCLES + 20;
  localparam slot_mask_t IDLE = EMPTY_SEL;

  logic       clk;
  logic       rst;
  logic       stall;
  slot_mask_t load;
  slot_mask_t store;
  slot_mask_t alu;
  slot_mask_t shift;
  slot_mask_t pos0, pos1, pos2, pos3, pos4, pos5, pos6, pos7, pos8;

  // stimulus table where t_hand marks entries with hand-computed ports
  logic       t_stall [TABLE_LEN];
  slot_mask_t t_store [TABLE_LEN];
  slot_mask_t t_load  [TABLE_LEN];
  slot_mask_t t_alu   [TABLE_LEN];
  slot_mask_t t_shift [TABLE_LEN];
  logic       t_hand  [TABLE_LEN];
  slot_mask_t t_exp   [TABLE_LEN][9];
  int         n_entries;

  int n_checks;
  int model_errors;
  int table_errors;
  int cycles;

  `include "distrib_model.svh"

  slot_distrib dut0 (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .load  (load),
    .store (store),
    .alu   (alu),
    .shift (shift),
    .pos0  (pos0),
    .pos1  (pos1),
    .pos2  (pos2),
    .pos3  (pos3),
    .pos4  (pos4),
    .pos5  (pos5),
    .pos6  (pos6),
    .pos7  (pos7),
    .pos8  (pos8)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic slot_mask_t slot_bit(input int k);
    return slot_mask_t'(1) << k;
  endfunction

  task automatic add_entry(input logic st, input slot_mask_t sto, input slot_mask_t ld,
                           input slot_mask_t al, input slot_mask_t sh);
    t_stall[n_entries] = st;
    t_store[n_entries] = sto;
    t_load[n_entries]  = ld;
    t_alu[n_entries]   = al;
    t_shift[n_entries] = sh;
    t_hand[n_entries]  = 1'b0;
    n_entries = n_entries + 1;
  endtask

  // hand expectation for the entry added last
  task automatic expect_ports(input slot_mask_t m0, input slot_mask_t m1, input slot_mask_t m2,
                              input slot_mask_t a0, input slot_mask_t a1, input slot_mask_t a2,
                              input slot_mask_t s0, input slot_mask_t s1, input slot_mask_t s2);
    int e;
    e = n_entries - 1;
    t_hand[e] = 1'b1;
    t_exp[e][0] = m0;
    t_exp[e][1] = m1;
    t_exp[e][2] = m2;
    t_exp[e][3] = a0;
    t_exp[e][4] = a1;
    t_exp[e][5] = a2;
    t_exp[e][6] = s0;
    t_exp[e][7] = s1;
    t_exp[e][8] = s2;
  endtask

  // sparse random masks that may overlap between classes
  task automatic add_random();
    logic [31:0] b0, b1, b2, b3;
    b0 = $urandom & $urandom;
    b1 = $urandom & $urandom;
    b2 = $urandom & $urandom;
    b3 = $urandom & $urandom;
    add_entry(($urandom % 4) == 0, b0[SLOT_CNT-1:0], b1[SLOT_CNT-1:0],
              b2[SLOT_CNT-1:0], b3[SLOT_CNT-1:0]);
  endtask

  task automatic build_table();
    n_entries = 0;
    // two stores ahead of the first load leave pointer r at 2
    add_entry(0, slot_bit(1) | slot_bit(4), slot_bit(0) | slot_bit(6), '0, '0);
    expect_ports(slot_bit(1), slot_bit(4), slot_bit(0), IDLE, IDLE, IDLE, IDLE, IDLE, IDLE);
    add_entry(0, '0, '0, '0, '0);
    expect_ports(IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, IDLE);
    add_entry(0, '0, '0, slot_bit(5), '0);
    expect_ports(IDLE, IDLE, IDLE, slot_bit(5), IDLE, IDLE, IDLE, IDLE, IDLE);
    // slot 2 in all four masks with 7 in load and shift and 9 in alu and shift
    add_entry(0, slot_bit(2), slot_bit(2) | slot_bit(7), slot_bit(2) | slot_bit(9),
              slot_bit(2) | slot_bit(7) | slot_bit(9));
    expect_ports(IDLE, slot_bit(2), slot_bit(7), slot_bit(9), IDLE, IDLE, IDLE, IDLE, IDLE);
    // memory rotation by loads only
    add_entry(0, '0, slot_bit(3), '0, '0);
    expect_ports(IDLE, IDLE, slot_bit(3), IDLE, IDLE, IDLE, IDLE, IDLE, IDLE);
    add_entry(0, '0, slot_bit(0) | slot_bit(8), '0, '0);
    expect_ports(slot_bit(0), slot_bit(8), IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, IDLE);
    add_entry(0, '0, slot_bit(1) | slot_bit(2) | slot_bit(5) | slot_bit(9), '0, '0);
    expect_ports(slot_bit(2), slot_bit(5), slot_bit(1), IDLE, IDLE, IDLE, IDLE, IDLE, IDLE);
    add_entry(0, '0, slot_bit(4), '0, '0);
    expect_ports(IDLE, IDLE, slot_bit(4), IDLE, IDLE, IDLE, IDLE, IDLE, IDLE);
    // stall keeps r so the rotation is the same before and after
    add_entry(0, '0, slot_bit(6) | slot_bit(7), '0, '0);
    expect_ports(slot_bit(6), slot_bit(7), IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, IDLE);
    add_entry(1, '0, slot_bit(0), '0, '0);
    expect_ports(IDLE, IDLE, slot_bit(0), IDLE, IDLE, IDLE, IDLE, IDLE, IDLE);
    add_entry(0, '0, slot_bit(0), '0, '0);
    expect_ports(IDLE, IDLE, slot_bit(0), IDLE, IDLE, IDLE, IDLE, IDLE, IDLE);
    // alu unrotated and shift rotated by s
    add_entry(0, '0, '0, slot_bit(1) | slot_bit(3) | slot_bit(8), slot_bit(0) | slot_bit(2));
    expect_ports(IDLE, IDLE, IDLE, slot_bit(1), slot_bit(3), slot_bit(8),
                 slot_bit(0), slot_bit(2), IDLE);
    add_entry(0, '0, '0, slot_bit(9), slot_bit(4) | slot_bit(5) | slot_bit(6));
    expect_ports(IDLE, IDLE, IDLE, slot_bit(9), IDLE, IDLE, slot_bit(5), slot_bit(6), slot_bit(4));
    add_entry(1, '0, '0, '0, slot_bit(7));
    expect_ports(IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, slot_bit(7));
    add_entry(0, '0, '0, '0, slot_bit(3));
    expect_ports(IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, IDLE, slot_bit(3));
    add_entry(0, slot_bit(0), slot_bit(1) | slot_bit(2) | slot_bit(3),
              slot_bit(4) | slot_bit(5), slot_bit(6) | slot_bit(7) | slot_bit(8));
    expect_ports(slot_bit(0), slot_bit(1), slot_bit(2), slot_bit(4), slot_bit(5), IDLE,
                 slot_bit(6), slot_bit(7), slot_bit(8));
    // four stores fill the group and leave no port for the load
    add_entry(0, slot_bit(5) | slot_bit(6) | slot_bit(7) | slot_bit(8), slot_bit(9), '0, '0);
    expect_ports(slot_bit(6), slot_bit(7), slot_bit(5), IDLE, IDLE, IDLE, IDLE, IDLE, IDLE);
    for (int k = 0; k < N_RANDOM; k++) begin
      add_random();
    end
  endtask

  task automatic check_outputs(input int idx);
    slot_mask_t got [9];
    got[0] = pos0;
    got[1] = pos1;
    got[2] = pos2;
    got[3] = pos3;
    got[4] = pos4;
    got[5] = pos5;
    got[6] = pos6;
    got[7] = pos7;
    got[8] = pos8;
    for (int p = 0; p < 9; p++) begin
      n_checks = n_checks + 1;
      assert (got[p] === model_pos[p]) else begin
        $display("FAIL %0t: entry %0d pos%0d is %b, model expects %b",
                 $time, idx, p, got[p], model_pos[p]);
        model_errors = model_errors + 1;
      end
      if (t_hand[idx]) begin
        assert (got[p] === t_exp[idx][p]) else begin
          $display("FAIL %0t: entry %0d pos%0d is %b, table expects %b",
                   $time, idx, p, got[p], t_exp[idx][p]);
          table_errors = table_errors + 1;
        end
      end
    end
  endtask

  // watchdog on clock cycles
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst   = 1'b1;
    stall = 1'b0;
    load  = '0;
    store = '0;
    alu   = '0;
    shift = '0;
    n_checks     = 0;
    model_errors = 0;
    table_errors = 0;
    void'($urandom(SEED));
    reset_model();
    build_table();
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      stall = t_stall[i];
      store = t_store[i];
      load  = t_load[i];
      alu   = t_alu[i];
      shift = t_shift[i];
      // sample shortly before the next rising edge
      #(CLK_PERIOD / 2 - 10);
      predict_ports(store, load, alu, shift);
      check_outputs(i);
      @(posedge clk);
      advance_pointers(stall, store, load, alu, shift);
      @(negedge clk);
    end
    $display("summary: %0d checks, %0d model mismatches, %0d table mismatches",
             n_checks, model_errors, table_errors);
    if (model_errors == 0 && table_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== hdl/slot_distrib.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot_distrib: dispatch slot distributor top, class
// resolver, one picker per class and the port router
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module slot_distrib (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall,
  input  dispatch_pkg::slot_mask_t load,
  input  dispatch_pkg::slot_mask_t store,
  input  dispatch_pkg::slot_mask_t alu,
  input  dispatch_pkg::slot_mask_t shift,
  output dispatch_pkg::slot_mask_t pos0,
  output dispatch_pkg::slot_mask_t pos1,
  output dispatch_pkg::slot_mask_t pos2,
  output dispatch_pkg::slot_mask_t pos3,
  output dispatch_pkg::slot_mask_t pos4,
  output dispatch_pkg::slot_mask_t pos5,
  output dispatch_pkg::slot_mask_t pos6,
  output dispatch_pkg::slot_mask_t pos7,
  output dispatch_pkg::slot_mask_t pos8
);
  import dispatch_pkg::*;

  // one lane per class, indexed by CLS_*
  lane_if lanes [0:NUM_CLASSES-1] ();

  class_resolve u_resolve (
    .load  (load),
    .store (store),
    .alu   (alu),
    .shift (shift),
    .lanes (lanes)
  );

  for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_pick
    slot_picker u_picker (
      .lane (lanes[c])
    );
  end

  port_router u_router (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .lanes (lanes),
    .pos0  (pos0),
    .pos1  (pos1),
    .pos2  (pos2),
    .pos3  (pos3),
    .pos4  (pos4),
    .pos5  (pos5),
    .pos6  (pos6),
    .pos7  (pos7),
    .pos8  (pos8)
  );

endmodule

// ==== hdl/port_router.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port_router: fills memory, ALU and shift port groups,
// rotates memory and shift groups, keeps both pointers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module port_router (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall,
  lane_if.router                   lanes [0:dispatch_pkg::NUM_CLASSES-1],
  output dispatch_pkg::slot_mask_t pos0,
  output dispatch_pkg::slot_mask_t pos1,
  output dispatch_pkg::slot_mask_t pos2,
  output dispatch_pkg::slot_mask_t pos3,
  output dispatch_pkg::slot_mask_t pos4,
  output dispatch_pkg::slot_mask_t pos5,
  output dispatch_pkg::slot_mask_t pos6,
  output dispatch_pkg::slot_mask_t pos7,
  output dispatch_pkg::slot_mask_t pos8
);
  import dispatch_pkg::*;

  slot_mask_t st_sel    [PORTS_PER_GROUP];
  slot_mask_t ld_sel    [PORTS_PER_GROUP];
  slot_mask_t sh_sel    [PORTS_PER_GROUP];
  slot_mask_t mem_entry [PORTS_PER_GROUP];

  port_cnt_t  st_cnt;
  port_cnt_t  ld_cnt;
  port_cnt_t  sh_cnt;

  group_ptr_t mem_ptr;
  group_ptr_t mem_ptr_d;
  group_ptr_t shift_ptr;
  group_ptr_t shift_ptr_d;

  // source entry seen by port i of a group rotated by p
  function automatic int rot_idx(input int i, input group_ptr_t p);
    return (i + int'(p)) % PORTS_PER_GROUP;
  endfunction

  assign st_sel = '{lanes[CLS_STORE].sel0, lanes[CLS_STORE].sel1, lanes[CLS_STORE].sel2};
  assign ld_sel = '{lanes[CLS_LOAD].sel0, lanes[CLS_LOAD].sel1, lanes[CLS_LOAD].sel2};
  assign sh_sel = '{lanes[CLS_SHIFT].sel0, lanes[CLS_SHIFT].sel1, lanes[CLS_SHIFT].sel2};

  assign st_cnt = lanes[CLS_STORE].cnt;
  assign ld_cnt = lanes[CLS_LOAD].cnt;
  assign sh_cnt = lanes[CLS_SHIFT].cnt;

  // stores first, loads fill the remaining memory entries
  always_comb begin
    for (int i = 0; i < PORTS_PER_GROUP; i++) begin
      if (i < int'(st_cnt)) begin
        mem_entry[i] = st_sel[i];
      end else begin
        mem_entry[i] = ld_sel[i - int'(st_cnt)];
      end
    end
  end

  assign pos0 = mem_entry[rot_idx(0, mem_ptr)];
  assign pos1 = mem_entry[rot_idx(1, mem_ptr)];
  assign pos2 = mem_entry[rot_idx(2, mem_ptr)];

  // ALU group is never rotated
  assign pos3 = lanes[CLS_ALU].sel0;
  assign pos4 = lanes[CLS_ALU].sel1;
  assign pos5 = lanes[CLS_ALU].sel2;

  assign pos6 = sh_sel[rot_idx(0, shift_ptr)];
  assign pos7 = sh_sel[rot_idx(1, shift_ptr)];
  assign pos8 = sh_sel[rot_idx(2, shift_ptr)];

  // pointers step back by the number of slots each group issued
  always_comb begin
    int room;
    int placed;
    room   = PORTS_PER_GROUP - int'(st_cnt);
    placed = (int'(ld_cnt) < room) ? int'(ld_cnt) : room;
    mem_ptr_d   = group_ptr_t'((int'(mem_ptr) + PORTS_PER_GROUP - placed)
                               % PORTS_PER_GROUP);
    shift_ptr_d = group_ptr_t'((int'(shift_ptr) + PORTS_PER_GROUP - int'(sh_cnt))
                               % PORTS_PER_GROUP);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_ptr   <= '0;
      shift_ptr <= '0;
    end else if (!stall) begin
      mem_ptr   <= mem_ptr_d;
      shift_ptr <= shift_ptr_d;
    end
  end

endmodule

// ==== hdl/slot_picker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot_picker: first three set slots of one class as one-hot
// selections, and the saturated slot count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module slot_picker (
  lane_if.picker lane
);
  import dispatch_pkg::*;

  // remaining mask before each pick
  slot_mask_t rest0;
  slot_mask_t rest1;
  slot_mask_t rest2;

  // isolated lowest bit of each remainder
  slot_mask_t low0;
  slot_mask_t low1;
  slot_mask_t low2;

  port_cnt_t  found;

  // two's complement trick, keeps only the lowest set bit
  function automatic slot_mask_t lowest_set(input slot_mask_t m);
    return m & (~m + 1'b1);
  endfunction

  assign rest0 = lane.mask;
  assign low0  = lowest_set(rest0);

  assign rest1 = rest0 & ~low0;
  assign low1  = lowest_set(rest1);

  assign rest2 = rest1 & ~low1;
  assign low2  = lowest_set(rest2);

  assign lane.sel0 = (low0 == '0) ? EMPTY_SEL : low0;
  assign lane.sel1 = (low1 == '0) ? EMPTY_SEL : low1;
  assign lane.sel2 = (low2 == '0) ? EMPTY_SEL : low2;

  // anything left after two picks means three or more
  always_comb begin
    if (rest2 != '0) begin
      found = 2'd3;
    end else if (rest1 != '0) begin
      found = 2'd2;
    end else if (rest0 != '0) begin
      found = 2'd1;
    end else begin
      found = 2'd0;
    end
  end

  assign lane.cnt = found;

endmodule

// ==== hdl/class_resolve.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// class_resolve: splits possibly overlapping class masks
// into one exclusive mask per lane
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module class_resolve (
  input  dispatch_pkg::slot_mask_t load,
  input  dispatch_pkg::slot_mask_t store,
  input  dispatch_pkg::slot_mask_t alu,
  input  dispatch_pkg::slot_mask_t shift,
  lane_if.resolver                 lanes [0:dispatch_pkg::NUM_CLASSES-1]
);
  import dispatch_pkg::*;

  // slots already owned by a higher class
  slot_mask_t mem_taken;
  slot_mask_t upper_taken;

  assign mem_taken   = store | load;
  assign upper_taken = mem_taken | alu;

  // store keeps every slot it names
  assign lanes[CLS_STORE].mask = store;

  // a load that is also a store issues as the store
  assign lanes[CLS_LOAD].mask  = load & ~store;

  assign lanes[CLS_ALU].mask   = alu & ~mem_taken;

  // shift only gets what nobody above wanted
  assign lanes[CLS_SHIFT].mask = shift & ~upper_taken;

endmodule

// ==== hdl/lane_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane_if: one instruction class, from the class resolver
// through its slot picker to the port router
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface lane_if;
  import dispatch_pkg::*;

  // exclusive class mask
  slot_mask_t mask;
  // first three slots of the class, EMPTY_SEL when absent
  slot_mask_t sel0;
  slot_mask_t sel1;
  slot_mask_t sel2;
  // slots found, saturated at 3
  port_cnt_t  cnt;

  modport resolver (output mask);
  modport picker   (input mask, output sel0, output sel1, output sel2, output cnt);
  modport router   (input sel0, input sel1, input sel2, input cnt);

endinterface

// ==== hdl/dispatch_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dispatch_pkg: bundle and port sizes, class lane indices,
// slot mask, group count and rotation pointer types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dispatch_pkg;

  // bundle and port geometry
  localparam int SLOT_CNT        = 10;
  localparam int PORTS_PER_GROUP = 3;
  localparam int NUM_CLASSES     = 4;

  // lane indices, also the overlap priority (lowest wins)
  localparam int CLS_STORE = 0;
  localparam int CLS_LOAD  = 1;
  localparam int CLS_ALU   = 2;
  localparam int CLS_SHIFT = 3;

  // one bit per slot; a port selection is one-hot in this form
  typedef logic [SLOT_CNT-1:0] slot_mask_t;

  // idle port marker
  localparam slot_mask_t EMPTY_SEL = '1;

  // slots placed in one port group, 0 to 3
  typedef logic [1:0] port_cnt_t;

  // rotation pointer of a port group, 0 to 2
  typedef logic [1:0] group_ptr_t;

endpackage
